/* common/wb_pkg.sv */
`default_nettype none

package wb_pkg;

    // --------------------
    // pixel and gain types
    // --------------------

    localparam int raw_bits = 10;

    typedef logic [raw_bits-1:0]    raw_pix_t;
    typedef logic [7:0]             out_pix_t;

    // unsigned fixed point with GAIN_FRAC fraction bits
    typedef logic [11:0]            gain_t;

    // --------------------
    // bayer mosaic
    // --------------------

    // {row odd, col odd} of an RGGB tile
    typedef enum logic [1:0] {
        PH_R    = 2'd0,
        PH_GR   = 2'd1,
        PH_GB   = 2'd2,
        PH_B    = 2'd3
    } bayer_phase_t;

    // --------------------
    // register map
    // --------------------

    typedef enum logic [1:0] {
        REG_GAIN_R  = 2'd0,
        REG_GAIN_GR = 2'd1,
        REG_GAIN_GB = 2'd2,
        REG_GAIN_B  = 2'd3
    } wb_reg_t;

endpackage

`default_nettype wire

/* common/pix_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface pix_if
    import wb_pkg::*;
    ();

    logic           valid;
    logic           ready;
    raw_pix_t       data;
    bayer_phase_t   phase;
    logic           sof;
    logic           eol;

    modport source (
        output  valid,
        input   ready,
        output  data,
        output  phase,
        output  sof,
        output  eol
    );

    modport sink (
        input   valid,
        output  ready,
        input   data,
        input   phase,
        input   sof,
        input   eol
    );

endinterface

`default_nettype wire

/* rtl/raw_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module raw_rx
    import wb_pkg::*;
    (
        input   logic       aclk        ,
        input   logic       rst_n       ,

        input   logic       in_valid    ,
        output  logic       in_ready    ,
        input   raw_pix_t   in_data     ,
        input   logic       in_sof      ,
        input   logic       in_eol      ,

        pix_if.source       m
    );

    logic   take;
    logic   row_odd;
    logic   col_odd;
    logic   row_cur;
    logic   col_cur;

    assign in_ready = !m.valid || m.ready;
    assign take     = in_valid && in_ready;

    // sof forces row 0, column 0
    assign row_cur = in_sof ? 1'b0 : row_odd;
    assign col_cur = in_sof ? 1'b0 : col_odd;

    // --------------------
    // phase tracking
    // --------------------

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            m.valid <= 1'b0;
            row_odd <= 1'b0;
            col_odd <= 1'b0;
        end else begin
            if (in_ready) begin
                m.valid <= in_valid;
            end
            if (take) begin
                if (in_eol) begin
                    row_odd <= ~row_cur;
                    col_odd <= 1'b0;
                end else begin
                    row_odd <= row_cur;
                    col_odd <= ~col_cur;
                end
            end
        end
    end

    // pixel register
    always_ff @(posedge aclk) begin
        if (take) begin
            m.data  <= in_data;
            m.phase <= bayer_phase_t'({row_cur, col_cur});
            m.sof   <= in_sof;
            m.eol   <= in_eol;
        end
    end

endmodule

`default_nettype wire

/* wb/wb_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_regs
    import wb_pkg::*;
    #(
        parameter int   GAIN_FRAC = 8
    )
    (
        input   logic       aclk        ,
        input   logic       rst_n       ,

        input   logic       reg_wr      ,
        input   wb_reg_t    reg_addr    ,
        input   gain_t      reg_wdata   ,

        output  gain_t      gain_r      ,
        output  gain_t      gain_gr     ,
        output  gain_t      gain_gb     ,
        output  gain_t      gain_b
    );

    // 1.0 in the gain format
    localparam gain_t unity = gain_t'(1 << GAIN_FRAC);

    // --------------------
    // write decode
    // --------------------

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            gain_r  <= unity;
            gain_gr <= unity;
            gain_gb <= unity;
            gain_b  <= unity;
        end else if (reg_wr) begin
            case (reg_addr)
                REG_GAIN_R:  gain_r  <= reg_wdata;
                REG_GAIN_GR: gain_gr <= reg_wdata;
                REG_GAIN_GB: gain_gb <= reg_wdata;
                REG_GAIN_B:  gain_b  <= reg_wdata;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

/* wb/wb_gain.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_gain
    import wb_pkg::*;
    #(
        parameter int   GAIN_FRAC = 8
    )
    (
        input   logic       aclk        ,
        input   logic       rst_n       ,

        pix_if.sink         s           ,
        pix_if.source       m           ,

        input   gain_t      gain_r      ,
        input   gain_t      gain_gr     ,
        input   gain_t      gain_gb     ,
        input   gain_t      gain_b
    );

    localparam int prod_bits = raw_bits + $bits(gain_t);
    localparam int round_c   = 1 << (GAIN_FRAC - 1);

    localparam logic [prod_bits:0] pix_max = (prod_bits + 1)'((1 << raw_bits) - 1);

    logic                   stall;
    logic                   en1;
    gain_t                  gain_sel;

    logic                   v1;
    logic [prod_bits-1:0]   prod1;
    bayer_phase_t           ph1;
    logic                   sof1;
    logic                   eol1;

    logic [prod_bits:0]     sum;
    logic [prod_bits:0]     scaled;
    raw_pix_t               clipped;

    // output held and not taken
    assign stall   = m.valid && !m.ready;
    assign en1     = !stall || !v1;
    assign s.ready = en1;

    always_comb begin
        case (s.phase)
            PH_R:    gain_sel = gain_r;
            PH_GR:   gain_sel = gain_gr;
            PH_GB:   gain_sel = gain_gb;
            default: gain_sel = gain_b;
        endcase
    end

    // round, shift, clip
    assign sum     = {1'b0, prod1} + (prod_bits + 1)'(round_c);
    assign scaled  = sum >> GAIN_FRAC;
    assign clipped = (scaled > pix_max) ? raw_pix_t'(pix_max) : raw_pix_t'(scaled);

    // --------------------
    // valid flags
    // --------------------

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            v1      <= 1'b0;
            m.valid <= 1'b0;
        end else begin
            if (en1) begin
                v1 <= s.valid;
            end
            if (!stall) begin
                m.valid <= v1;
            end
        end
    end

    // --------------------
    // payload
    // --------------------

    always_ff @(posedge aclk) begin
        if (en1 && s.valid) begin
            prod1 <= s.data * gain_sel;
            ph1   <= s.phase;
            sof1  <= s.sof;
            eol1  <= s.eol;
        end
        if (!stall && v1) begin
            m.data  <= clipped;
            m.phase <= ph1;
            m.sof   <= sof1;
            m.eol   <= eol1;
        end
    end

endmodule

`default_nettype wire

/* rtl/raw_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module raw_tx
    import wb_pkg::*;
    (
        input   logic       aclk        ,
        input   logic       rst_n       ,

        pix_if.sink         s           ,

        output  logic       out_valid   ,
        input   logic       out_ready   ,
        output  out_pix_t   out_data    ,
        output  logic       out_sof     ,
        output  logic       out_eol
    );

    logic   take;

    // empty, or current word leaves this cycle
    assign s.ready = !out_valid || out_ready;
    assign take    = s.valid && s.ready;

    // --------------------
    // output register
    // --------------------

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (s.ready) begin
            out_valid <= s.valid;
        end
    end

    // keep the top 8 bits
    always_ff @(posedge aclk) begin
        if (take) begin
            out_data <= s.data[raw_bits-1 -: $bits(out_pix_t)];
            out_sof  <= s.sof;
            out_eol  <= s.eol;
        end
    end

endmodule

`default_nettype wire

/* rtl/cam_wb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cam_wb_top
    import wb_pkg::*;
    #(
        parameter int   GAIN_FRAC = 8
    )
    (
        input   logic       aclk        ,
        input   logic       rst_n       ,

        input   logic       in_valid    ,
        output  logic       in_ready    ,
        input   raw_pix_t   in_data     ,
        input   logic       in_sof      ,
        input   logic       in_eol      ,

        output  logic       out_valid   ,
        input   logic       out_ready   ,
        output  out_pix_t   out_data    ,
        output  logic       out_sof     ,
        output  logic       out_eol     ,

        input   logic       reg_wr      ,
        input   wb_reg_t    reg_addr    ,
        input   gain_t      reg_wdata
    );

    gain_t  gain_r;
    gain_t  gain_gr;
    gain_t  gain_gb;
    gain_t  gain_b;

    pix_if  s_rx   ();
    pix_if  s_gain ();

    // --------------------
    // stream path
    // --------------------

    raw_rx
        raw_rx_i
            (
                .aclk       (aclk       ),
                .rst_n      (rst_n      ),
                .in_valid   (in_valid   ),
                .in_ready   (in_ready   ),
                .in_data    (in_data    ),
                .in_sof     (in_sof     ),
                .in_eol     (in_eol     ),
                .m          (s_rx       )
            );

    wb_gain
            #(
                .GAIN_FRAC  (GAIN_FRAC  )
            )
        wb_gain_i
            (
                .aclk       (aclk       ),
                .rst_n      (rst_n      ),
                .s          (s_rx       ),
                .m          (s_gain     ),
                .gain_r     (gain_r     ),
                .gain_gr    (gain_gr    ),
                .gain_gb    (gain_gb    ),
                .gain_b     (gain_b     )
            );

    raw_tx
        raw_tx_i
            (
                .aclk       (aclk       ),
                .rst_n      (rst_n      ),
                .s          (s_gain     ),
                .out_valid  (out_valid  ),
                .out_ready  (out_ready  ),
                .out_data   (out_data   ),
                .out_sof    (out_sof    ),
                .out_eol    (out_eol    )
            );

    // --------------------
    // gain registers
    // --------------------

    wb_regs
            #(
                .GAIN_FRAC  (GAIN_FRAC  )
            )
        wb_regs_i
            (
                .aclk       (aclk       ),
                .rst_n      (rst_n      ),
                .reg_wr     (reg_wr     ),
                .reg_addr   (reg_addr   ),
                .reg_wdata  (reg_wdata  ),
                .gain_r     (gain_r     ),
                .gain_gr    (gain_gr    ),
                .gain_gb    (gain_gb    ),
                .gain_b     (gain_b     )
            );

endmodule

`default_nettype wire

/* test/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD     = 40,
    parameter int RST_CYCLES = 2
) (
    input  logic rst_req,
    output logic aclk,
    output logic rst_n
);

    int cnt = 0;

    initial begin
        aclk  = 1'b0;
        rst_n = 1'b0;
        forever #(PERIOD / 2) aclk = ~aclk;
    end

    // rst_req restarts the reset pulse
    always @(posedge aclk) begin
        if (rst_req) begin
            rst_n <= 1'b0;
            cnt   <= 0;
        end else if (!rst_n) begin
            if (cnt == RST_CYCLES - 1) begin
                rst_n <= 1'b1;
            end
            cnt <= cnt + 1;
        end
    end

endmodule

`default_nettype wire

/* test/cam_wb_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module cam_wb_sva
    import wb_pkg::*;
    (
        input logic     aclk,
        input logic     rst_n,
        input logic     out_valid,
        input logic     out_ready,
        input out_pix_t out_data,
        input logic     out_sof,
        input logic     out_eol
    );

    // eol of the last pixel that left
    logic last_eol;

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            last_eol <= 1'b1;
        end else if (out_valid && out_ready) begin
            last_eol <= out_eol;
        end
    end

    // --------------------
    // output stream
    // --------------------

    hold_under_stall: assert property (@(posedge aclk) disable iff (!rst_n)
        out_valid && !out_ready |=> $stable(out_data) && $stable(out_sof) && $stable(out_eol))
        else $error("output payload changed while stalled");

    idle_after_reset: assert property (@(posedge aclk) !rst_n |=> !out_valid)
        else $error("out_valid high right after reset");

    sof_after_eol: assert property (@(posedge aclk) disable iff (!rst_n)
        out_valid && out_ready && out_sof |-> last_eol)
        else $error("sof on a pixel that follows one without eol");

endmodule

bind cam_wb_top cam_wb_sva cam_wb_sva_i (
    .aclk      (aclk),
    .rst_n     (rst_n),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data),
    .out_sof   (out_sof),
    .out_eol   (out_eol)
);

`default_nettype wire

/* test/tb_cam_wb.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cam_wb
    import wb_pkg::*;
    ();

    localparam int cols       = 16;
    localparam int total_rows = 57;
    localparam int max_cycles = 20 * total_rows * cols + 200;
    localparam int seed_init  = 48915;

    typedef struct packed {
        out_pix_t data;
        logic     sof;
        logic     eol;
    } exp_t;

    logic     aclk;
    logic     rst_n;
    logic     rst_req;
    logic     in_valid;
    logic     in_ready;
    raw_pix_t in_data;
    logic     in_sof;
    logic     in_eol;
    logic     out_valid;
    logic     out_ready = 1'b1;
    out_pix_t out_data;
    logic     out_sof;
    logic     out_eol;
    logic     reg_wr;
    wb_reg_t  reg_addr;
    gain_t    reg_wdata;

    int    seed    = seed_init;
    int    bp_seed = seed_init + 1;
    bit    bp_on   = 1'b0;
    int    cycles  = 0;
    int    row_m   = 0;
    int    col_m   = 0;
    gain_t gains [4];
    exp_t  exp_q [$];
    exp_t  pushed;
    exp_t  head;

    tb_clock clock_i (
        .rst_req (rst_req),
        .aclk    (aclk),
        .rst_n   (rst_n)
    );

    cam_wb_top #(.GAIN_FRAC(8)) cam_wb_top_i (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .in_sof    (in_sof),
        .in_eol    (in_eol),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .out_sof   (out_sof),
        .out_eol   (out_eol),
        .reg_wr    (reg_wr),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata)
    );

    // --------------------
    // reference and checks
    // --------------------

    // RGGB phase, round by half of 1.0, clip to 10 bits, keep top 8
    function automatic out_pix_t ref_pix(input int row, input int col, input raw_pix_t raw,
                                         input gain_t g_r, input gain_t g_gr,
                                         input gain_t g_gb, input gain_t g_b);
        gain_t       g;
        int unsigned scaled;
        if (row % 2 == 0) begin
            g = (col % 2 == 0) ? g_r : g_gr;
        end else begin
            g = (col % 2 == 0) ? g_gb : g_b;
        end
        scaled = (32'(raw) * 32'(g) + 128) / 256;
        if (scaled > 1023) begin
            scaled = 1023;
        end
        return out_pix_t'(scaled / 4);
    endfunction

    task automatic stop_run();
        $display("FAIL: see errors above");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_pix(input string name, input out_pix_t got, input out_pix_t exp);
        if (got !== exp) begin
            $display("MISMATCH time %0t: %s got %0d expected %0d", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH time %0t: %s got %b expected %b", $time, name, got, exp);
            stop_run();
        end
    endtask

    // input monitor with its own row and column count
    always @(posedge aclk) begin
        if (rst_n && in_valid && in_ready) begin
            if (in_sof) begin
                row_m = 0;
                col_m = 0;
            end
            pushed.data = ref_pix(row_m, col_m, in_data, gains[0], gains[1], gains[2], gains[3]);
            pushed.sof  = in_sof;
            pushed.eol  = in_eol;
            exp_q.push_back(pushed);
            if (in_eol) begin
                row_m = row_m + 1;
                col_m = 0;
            end else begin
                col_m = col_m + 1;
            end
        end
    end

    // scoreboard
    always @(posedge aclk) begin
        if (rst_n) begin
            if (!in_ready && out_ready) begin
                $display("in_ready low at time %0t while out_ready is high", $time);
                stop_run();
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    $display("output pixel at time %0t with no input pixel to match", $time);
                    stop_run();
                end else begin
                    head = exp_q.pop_front();
                    check_pix("out_data", out_data, head.data);
                    check_flag("out_sof", out_sof, head.sof);
                    check_flag("out_eol", out_eol, head.eol);
                end
            end
        end
    end

    always @(posedge aclk) begin
        cycles = cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout after %0d cycles with %0d pixels outstanding", cycles, exp_q.size());
            stop_run();
        end
    end

    always @(posedge aclk) begin
        if (bp_on) begin
            out_ready <= ($random(bp_seed) & 3) != 0;
        end else begin
            out_ready <= 1'b1;
        end
    end

    // --------------------
    // stimulus
    // --------------------

    function automatic raw_pix_t make_pix(input int kind);
        int r;
        r = $random(seed);
        if (kind == 0) begin
            return raw_pix_t'(r);
        end
        // bright or dark
        if ((r & 1) != 0) begin
            return raw_pix_t'(1023 - ((r >>> 4) & 63));
        end
        return raw_pix_t'((r >>> 4) & 31);
    endfunction

    task automatic wait_reset();
        @(posedge aclk);
        while (!rst_n) @(posedge aclk);
    endtask

    task automatic reset_dut();
        rst_req <= 1'b1;
        @(posedge aclk);
        rst_req <= 1'b0;
        wait_reset();
        gains = '{4{gain_t'(256)}};
    endtask

    task automatic write_gain(input wb_reg_t addr, input gain_t val);
        reg_wr    <= 1'b1;
        reg_addr  <= addr;
        reg_wdata <= val;
        @(posedge aclk);
        reg_wr <= 1'b0;
        gains[int'(addr)] = val;
    endtask

    task automatic set_gains(input gain_t g_r, input gain_t g_gr,
                             input gain_t g_gb, input gain_t g_b);
        write_gain(REG_GAIN_R, g_r);
        write_gain(REG_GAIN_GR, g_gr);
        write_gain(REG_GAIN_GB, g_gb);
        write_gain(REG_GAIN_B, g_b);
    endtask

    task automatic send_pix(input raw_pix_t d, input logic sof, input logic eol, input bit gaps);
        int idle;
        idle = 0;
        if (gaps) begin
            idle = $random(seed) & 7;
            if (idle > 2) begin
                idle = 0;
            end
        end
        if (idle > 0) begin
            in_valid <= 1'b0;
            repeat (idle) @(posedge aclk);
        end
        in_valid <= 1'b1;
        in_data  <= d;
        in_sof   <= sof;
        in_eol   <= eol;
        @(posedge aclk);
        while (!in_ready) @(posedge aclk);
    endtask

    task automatic send_frame(input int rows, input int kind, input bit gaps);
        for (int r = 0; r < rows; r++) begin
            for (int c = 0; c < cols; c++) begin
                send_pix(make_pix(kind), r == 0 && c == 0, c == cols - 1, gaps);
            end
        end
    endtask

    task automatic drain();
        in_valid <= 1'b0;
        @(posedge aclk);
        while (exp_q.size() != 0) @(posedge aclk);
        repeat (2) @(posedge aclk);
    endtask

    initial begin
        rst_req   <= 1'b0;
        in_valid  <= 1'b0;
        in_data   <= '0;
        in_sof    <= 1'b0;
        in_eol    <= 1'b0;
        reg_wr    <= 1'b0;
        reg_addr  <= REG_GAIN_R;
        reg_wdata <= '0;
        gains = '{4{gain_t'(256)}};
        wait_reset();

        // unity gains
        send_frame(6, 0, 1'b0);
        drain();

        // per phase gains
        set_gains(12'd400, 12'd300, 12'd200, 12'd512);
        send_frame(6, 0, 1'b0);
        drain();

        // clipping and rounding
        set_gains(12'd4095, 12'd2048, 12'd1536, 12'd1024);
        send_frame(6, 1, 1'b0);
        drain();

        // back-pressure and input gaps
        set_gains(12'd333, 12'd256, 12'd271, 12'd450);
        bp_on = 1'b1;
        send_frame(6, 0, 1'b1);
        send_frame(6, 0, 1'b1);
        drain();
        bp_on = 1'b0;

        // short frame, then sof mid-stream on an odd row
        send_frame(3, 0, 1'b0);
        send_frame(6, 0, 1'b0);
        drain();

        // gain write between frames, then reset
        send_frame(6, 0, 1'b0);
        drain();
        set_gains(12'd128, 12'd700, 12'd90, 12'd1000);
        send_frame(6, 0, 1'b0);
        drain();
        reset_dut();
        send_frame(6, 0, 1'b0);
        drain();

        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
common/wb_pkg.sv
common/pix_if.sv
rtl/raw_rx.sv
wb/wb_regs.sv
wb/wb_gain.sv
rtl/raw_tx.sv
rtl/cam_wb_top.sv
test/tb_clock.sv
test/cam_wb_sva.sv
test/tb_cam_wb.sv

/* Makefile */
# Verilator build and run of the white-balance testbench

VERILATOR ?= verilator
TOP       ?= tb_cam_wb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= PASS: all tests

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
